// ==== design/branch_predict_unit.sv ====
`timescale 1ns/1ps

// Branch prediction unit for the fetch stage
// Jump target table and return stack look up in parallel from the
// fetch PC, and the selector folds in the execute redirect
module branch_predict_unit (
    input  logic                  clk,
    input  logic                  reset,
    // Fetch stage
    input  logic                  if_valid,
    input  logic [31:0]           pc_if,
    input  logic [31:0]           pc4_if,
    input  ir_type_pkg::ir_type_e ir_type_if,
    // Execute stage
    input  logic                  ex_valid,
    input  logic [31:0]           pc_ex,
    input  ir_type_pkg::ir_type_e ir_type_ex,
    input  logic                  resolved_taken,
    input  logic [31:0]           jump_addr_ex,
    input  logic                  is_prediction_wrong,
    // Back to fetch
    output logic [31:0]           next_pc,
    output logic                  predict_taken
);

    logic        table_hit;
    logic [31:0] table_target;
    logic        ras_valid;
    logic [31:0] ras_target;

    jump_target_table u_jump_target_table (
        .clk            (clk),
        .reset          (reset),
        .pc_if          (pc_if),
        .ir_type_if     (ir_type_if),
        .ex_valid       (ex_valid),
        .pc_ex          (pc_ex),
        .ir_type_ex     (ir_type_ex),
        .resolved_taken (resolved_taken),
        .jump_addr_ex   (jump_addr_ex),
        .table_hit      (table_hit),
        .table_target   (table_target)
    );

    return_address_stack u_return_address_stack (
        .clk        (clk),
        .reset      (reset),
        .if_valid   (if_valid),
        .ir_type_if (ir_type_if),
        .pc4_if     (pc4_if),
        .ras_valid  (ras_valid),
        .ras_target (ras_target)
    );

    next_pc_select u_next_pc_select (
        .ir_type_if          (ir_type_if),
        .pc4_if              (pc4_if),
        .ex_valid            (ex_valid),
        .is_prediction_wrong (is_prediction_wrong),
        .resolved_taken      (resolved_taken),
        .jump_addr_ex        (jump_addr_ex),
        .pc_ex               (pc_ex),
        .ras_valid           (ras_valid),
        .ras_target          (ras_target),
        .table_hit           (table_hit),
        .table_target        (table_target),
        .next_pc             (next_pc),
        .predict_taken       (predict_taken)
    );

endmodule

// ==== design/ir_type_pkg.sv ====
package ir_type_pkg;

    // Predecoded instruction kind, produced ahead of the predictor by the
    // fetch stage predecoder and again by execute when the instruction resolves
    typedef enum logic [3:0] {
        // Not a control transfer
        ir_other  = 4'd0,
        // Conditional branch (BEQ, BNE, BLT...)
        ir_branch = 4'd1,
        // Direct jump, no link
        ir_jal    = 4'd2,
        // Indirect jump, no link
        ir_jalr   = 4'd3,
        // JAL or JALR writing ra, pushes the return address
        ir_call   = 4'd4,
        // JALR through ra without link, pops the return address
        ir_ret    = 4'd5
    } ir_type_e;

endpackage

// ==== design/jump_target_table.sv ====
`timescale 1ns/1ps

// Direct-mapped jump target table
// One 2-bit direction state and one target per entry.
// Lookup is combinational at the fetch PC, training lands at the clock edge
// at the execute PC, so a same-cycle lookup of that entry sees the old value
module jump_target_table (
    input  logic                  clk,
    input  logic                  reset,
    // Fetch side lookup
    input  logic [31:0]           pc_if,
    input  ir_type_pkg::ir_type_e ir_type_if,
    // Execute side training
    input  logic                  ex_valid,
    input  logic [31:0]           pc_ex,
    input  ir_type_pkg::ir_type_e ir_type_ex,
    input  logic                  resolved_taken,
    input  logic [31:0]           jump_addr_ex,
    // To the next PC selector
    output logic                  table_hit,
    output logic [31:0]           table_target
);

    predictor_pkg::pred_state_e state_mem [predictor_pkg::TABLE_SIZE];
    logic [31:0]                target_mem [predictor_pkg::TABLE_SIZE];

    logic [predictor_pkg::INDEX_BITS-1:0] fetch_index;
    logic [predictor_pkg::INDEX_BITS-1:0] update_index;
    predictor_pkg::pred_state_e           fetch_state;
    predictor_pkg::pred_state_e           update_state;
    logic                                 fetch_is_ctrl;
    logic                                 update_en;

    // Word-aligned PC bits above the byte offset select the entry
    function automatic logic [predictor_pkg::INDEX_BITS-1:0] entry_index(
        input logic [31:0] pc
    );
        return pc[predictor_pkg::INDEX_BITS+1:2];
    endfunction

    // One saturating step toward the resolved direction
    function automatic predictor_pkg::pred_state_e step_state(
        input predictor_pkg::pred_state_e cur,
        input logic                       taken
    );
        predictor_pkg::pred_state_e nxt;
        if (taken) begin
            case (cur)
                predictor_pkg::strong_dont_take: nxt = predictor_pkg::weak_dont_take;
                predictor_pkg::weak_dont_take:   nxt = predictor_pkg::weak_take;
                default:                         nxt = predictor_pkg::strong_take;
            endcase
        end else begin
            case (cur)
                predictor_pkg::strong_take: nxt = predictor_pkg::weak_take;
                predictor_pkg::weak_take:   nxt = predictor_pkg::weak_dont_take;
                default:                    nxt = predictor_pkg::strong_dont_take;
            endcase
        end
        return nxt;
    endfunction

    // Lookup
    assign fetch_index   = entry_index(pc_if);
    assign fetch_state   = state_mem[fetch_index];
    assign fetch_is_ctrl = (ir_type_if != ir_type_pkg::ir_other);

    // Only a control instruction leaning taken counts as a hit
    assign table_hit    = fetch_is_ctrl &&
                          ((fetch_state == predictor_pkg::weak_take) ||
                           (fetch_state == predictor_pkg::strong_take));
    assign table_target = target_mem[fetch_index];

    // Training from execute
    assign update_index = entry_index(pc_ex);
    assign update_state = step_state(state_mem[update_index], resolved_taken);
    assign update_en    = ex_valid && (ir_type_ex != ir_type_pkg::ir_other);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < predictor_pkg::TABLE_SIZE; i++) begin
                state_mem[i] <= predictor_pkg::RESET_STATE;
            end
        end else if (update_en) begin
            state_mem[update_index] <= update_state;
        end
    end

    // Target only changes on a taken resolution, so a not-taken branch
    // keeps the last known destination for when it flips back
    always_ff @(posedge clk) begin
        if (update_en && resolved_taken) begin
            target_mem[update_index] <= jump_addr_ex;
        end
    end

    // States read at fetch and written from execute stay within the encoding
    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        (fetch_state inside {predictor_pkg::strong_dont_take,
                             predictor_pkg::weak_dont_take,
                             predictor_pkg::weak_take,
                             predictor_pkg::strong_take}) &&
        (!update_en || (update_state inside {predictor_pkg::strong_dont_take,
                                             predictor_pkg::weak_dont_take,
                                             predictor_pkg::weak_take,
                                             predictor_pkg::strong_take})))
        else $error("jump_target_table: illegal predictor state");

endmodule

// ==== design/next_pc_select.sv ====
`timescale 1ns/1ps

// Next fetch PC selection
// Priority: execute redirect, then return stack, then jump table,
// then sequential fall-through
module next_pc_select (
    input  ir_type_pkg::ir_type_e ir_type_if,
    input  logic [31:0]           pc4_if,
    // Execute stage resolution
    input  logic                  ex_valid,
    input  logic                  is_prediction_wrong,
    input  logic                  resolved_taken,
    input  logic [31:0]           jump_addr_ex,
    input  logic [31:0]           pc_ex,
    // Predictor results
    input  logic                  ras_valid,
    input  logic [31:0]           ras_target,
    input  logic                  table_hit,
    input  logic [31:0]           table_target,
    output logic [31:0]           next_pc,
    output logic                  predict_taken
);

    logic        redirect;
    logic        ras_pick;
    logic [31:0] correct_pc;

    assign redirect = ex_valid && is_prediction_wrong;

    // Where execute says the mispredicted instruction really goes
    assign correct_pc = resolved_taken ? jump_addr_ex : (pc_ex + 32'd4);

    assign ras_pick = (ir_type_if == ir_type_pkg::ir_ret) && ras_valid;

    always_comb begin
        if (redirect) begin
            // Not a prediction, just the correction
            next_pc       = correct_pc;
            predict_taken = 1'b0;
        end else if (ras_pick) begin
            next_pc       = ras_target;
            predict_taken = 1'b1;
        end else if (table_hit) begin
            next_pc       = table_target;
            predict_taken = 1'b1;
        end else begin
            next_pc       = pc4_if;
            predict_taken = 1'b0;
        end
    end

endmodule

// ==== design/predictor_pkg.sv ====
package predictor_pkg;

    // 2-bit saturating direction state of one table entry
    // The upper bit alone tells the predicted direction
    typedef enum logic [1:0] {
        strong_dont_take = 2'b00,
        weak_dont_take   = 2'b01,
        weak_take        = 2'b10,
        strong_take      = 2'b11
    } pred_state_e;

    // Jump target table geometry
    localparam int TABLE_SIZE = 32;
    // Index is taken from pc[INDEX_BITS+1:2]
    localparam int INDEX_BITS = 5;

    // Return address stack geometry
    localparam int RAS_DEPTH    = 8;
    localparam int RAS_PTR_BITS = 3;

    // State of every table entry coming out of reset
    localparam pred_state_e RESET_STATE = weak_dont_take;

endpackage

// ==== design/return_address_stack.sv ====
`timescale 1ns/1ps

// Return address stack
// Circular buffer indexed by a top pointer, with a separate occupancy count.
// Calls push the fall-through PC and returns pop it, both only while the
// fetch slot is valid. Overflow silently drops the oldest return address
module return_address_stack (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  if_valid,
    input  ir_type_pkg::ir_type_e ir_type_if,
    input  logic [31:0]           pc4_if,
    output logic                  ras_valid,
    output logic [31:0]           ras_target
);

    logic [31:0] stack_mem [predictor_pkg::RAS_DEPTH];

    logic [predictor_pkg::RAS_PTR_BITS-1:0] top;
    logic [predictor_pkg::RAS_PTR_BITS-1:0] push_slot;
    logic [predictor_pkg::RAS_PTR_BITS:0]   count;
    logic                                   push;
    logic                                   pop;
    logic                                   full;

    assign push      = if_valid && (ir_type_if == ir_type_pkg::ir_call);
    // A return on an empty stack leaves everything alone
    assign pop       = if_valid && (ir_type_if == ir_type_pkg::ir_ret) && (count != '0);
    assign full      = (count == (predictor_pkg::RAS_PTR_BITS+1)'(predictor_pkg::RAS_DEPTH));
    assign push_slot = top + 1'b1;

    assign ras_valid  = (count != '0);
    assign ras_target = stack_mem[top];

    // Pointer and count
    always_ff @(posedge clk) begin
        if (reset) begin
            top   <= '0;
            count <= '0;
        end else if (push) begin
            top <= push_slot;
            // Wrapping onto the oldest slot keeps the count pinned at depth
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            top   <= top - 1'b1;
            count <= count - 1'b1;
        end
    end

    // Return address storage
    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[push_slot] <= pc4_if;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= (predictor_pkg::RAS_PTR_BITS+1)'(predictor_pkg::RAS_DEPTH))
        else $error("return_address_stack: count above depth");

endmodule

// ==== flist.f ====
design/ir_type_pkg.sv
design/predictor_pkg.sv
design/jump_target_table.sv
design/return_address_stack.sv
design/next_pc_select.sv
design/branch_predict_unit.sv
testbench/predict_checker.sv
testbench/tb_branch_predict_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the branch prediction unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    --top-module tb_branch_predict_unit \
    -f flist.f \
    -o sim_tb

# Keep going on a nonzero exit so the output is still shown and searched
output=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "PASS: all tests"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== testbench/predict_checker.sv ====
`timescale 1ns/1ps

// Cycle-by-cycle reference model of the branch prediction unit
// Keeps its own table states, targets and return stack, updated at each
// rising edge, and compares the DUT outputs at the falling edge
module predict_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  if_valid,
    input  logic [31:0]           pc_if,
    input  logic [31:0]           pc4_if,
    input  ir_type_pkg::ir_type_e ir_type_if,
    input  logic                  ex_valid,
    input  logic [31:0]           pc_ex,
    input  ir_type_pkg::ir_type_e ir_type_ex,
    input  logic                  resolved_taken,
    input  logic [31:0]           jump_addr_ex,
    input  logic                  is_prediction_wrong,
    input  logic [31:0]           next_pc,
    input  logic                  predict_taken,
    output int                    error_count,
    output int                    check_count
);

    // State kept as 0..3, strong_dont_take up to strong_take
    int          state_model  [int];
    logic [31:0] target_model [int];
    // Oldest return address at the front, newest at the back
    logic [31:0] stack_model  [$];
    int          errors = 0;
    int          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // Word address modulo the table size
    function automatic int entry_of(input logic [31:0] pc);
        return int'((pc >> 2) % 32'(predictor_pkg::TABLE_SIZE));
    endfunction

    function automatic void predict_ref(
        input  logic                  redirect,
        input  logic                  ex_taken,
        input  logic [31:0]           ex_target,
        input  logic [31:0]           ex_pc,
        input  ir_type_pkg::ir_type_e kind,
        input  logic [31:0]           fall_through,
        input  int                    stack_size,
        input  logic [31:0]           stack_top,
        input  int                    entry_state,
        input  logic [31:0]           entry_target,
        output logic [31:0]           exp_pc,
        output logic                  exp_taken
    );
        if (redirect) begin
            exp_pc    = ex_taken ? ex_target : ex_pc + 32'd4;
            exp_taken = 1'b0;
        end else if (kind == ir_type_pkg::ir_ret && stack_size > 0) begin
            exp_pc    = stack_top;
            exp_taken = 1'b1;
        end else if (kind != ir_type_pkg::ir_other &&
                     entry_state >= int'(predictor_pkg::weak_take)) begin
            exp_pc    = entry_target;
            exp_taken = 1'b1;
        end else begin
            exp_pc    = fall_through;
            exp_taken = 1'b0;
        end
    endfunction

    // Model update on the same edge that updates the DUT
    always @(posedge clk) begin : model_update
        int idx;
        if (reset) begin
            for (int i = 0; i < predictor_pkg::TABLE_SIZE; i++) begin
                state_model[i] = int'(predictor_pkg::RESET_STATE);
            end
            stack_model.delete();
        end else begin
            if (ex_valid && ir_type_ex != ir_type_pkg::ir_other) begin
                idx = entry_of(pc_ex);
                if (resolved_taken) begin
                    if (state_model[idx] < int'(predictor_pkg::strong_take)) begin
                        state_model[idx]++;
                    end
                    target_model[idx] = jump_addr_ex;
                end else if (state_model[idx] > int'(predictor_pkg::strong_dont_take)) begin
                    state_model[idx]--;
                end
            end
            if (if_valid && ir_type_if == ir_type_pkg::ir_call) begin
                stack_model.push_back(pc4_if);
                if (stack_model.size() > predictor_pkg::RAS_DEPTH) begin
                    void'(stack_model.pop_front());
                end
            end else if (if_valid && ir_type_if == ir_type_pkg::ir_ret &&
                         stack_model.size() > 0) begin
                void'(stack_model.pop_back());
            end
        end
    end

    // Inputs change 1 ns after the rising edge, so mid-cycle is settled
    always @(negedge clk) begin : compare
        logic [31:0] exp_pc;
        logic        exp_taken;
        logic [31:0] top_addr;
        logic [31:0] tgt;
        int          idx;
        if (!reset) begin
            idx      = entry_of(pc_if);
            top_addr = (stack_model.size() > 0) ? stack_model[$] : '0;
            tgt      = target_model.exists(idx) ? target_model[idx] : '0;
            predict_ref(ex_valid && is_prediction_wrong, resolved_taken, jump_addr_ex,
                        pc_ex, ir_type_if, pc4_if, stack_model.size(), top_addr,
                        state_model[idx], tgt, exp_pc, exp_taken);
            checks++;
            if (next_pc !== exp_pc) begin
                $display("ERR %0t next_pc expected %h actual %h", $time, exp_pc, next_pc);
                errors++;
            end
            if (predict_taken !== exp_taken) begin
                $display("ERR %0t predict_taken expected %b actual %b",
                         $time, exp_taken, predict_taken);
                errors++;
            end
        end
    end

endmodule

// ==== testbench/tb_branch_predict_unit.sv ====
`timescale 1ns/1ps

module tb_branch_predict_unit;

    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 300;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    // Test length plus margin, rounded to whole hundreds
    localparam int TIMEOUT_CYCLES  = (TEST_CYCLES + 700) / 100 * 100;

    // Same table index 16, differ only in bit 7
    localparam logic [31:0] PC_A     = 32'h0000_1040;
    localparam logic [31:0] PC_B     = 32'h0000_10c0;
    localparam logic [31:0] TARGET_A = 32'h0000_2000;
    localparam logic [31:0] TARGET_B = 32'h0000_3000;

    logic                  clk;
    logic                  reset;
    logic                  if_valid;
    logic [31:0]           pc_if;
    logic [31:0]           pc4_if;
    ir_type_pkg::ir_type_e ir_type_if;
    logic                  ex_valid;
    logic [31:0]           pc_ex;
    ir_type_pkg::ir_type_e ir_type_ex;
    logic                  resolved_taken;
    logic [31:0]           jump_addr_ex;
    logic                  is_prediction_wrong;
    logic [31:0]           next_pc;
    logic                  predict_taken;

    int          cycle_count     = 0;
    int          directed_errors = 0;
    int          checker_errors;
    int          checks_done;
    int unsigned seed_dummy;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    branch_predict_unit dut (.*);

    predict_checker chk (
        .*,
        .error_count (checker_errors),
        .check_count (checks_done)
    );

    task automatic clear_inputs();
        if_valid            = 1'b0;
        pc_if               = '0;
        pc4_if              = 32'd4;
        ir_type_if          = ir_type_pkg::ir_other;
        ex_valid            = 1'b0;
        pc_ex               = '0;
        ir_type_ex          = ir_type_pkg::ir_other;
        resolved_taken      = 1'b0;
        jump_addr_ex        = '0;
        is_prediction_wrong = 1'b0;
    endtask

    // Drive point of the next cycle, inputs back to quiet
    task automatic next_cycle();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    task automatic fetch_instr(input logic valid, input logic [31:0] pc,
                               input ir_type_pkg::ir_type_e kind);
        if_valid   = valid;
        pc_if      = pc;
        pc4_if     = pc + 32'd4;
        ir_type_if = kind;
    endtask

    task automatic report_resolve(input logic [31:0] pc, input ir_type_pkg::ir_type_e kind,
                                  input logic taken, input logic [31:0] target,
                                  input logic wrong);
        ex_valid            = 1'b1;
        pc_ex               = pc;
        ir_type_ex          = kind;
        resolved_taken      = taken;
        jump_addr_ex        = target;
        is_prediction_wrong = wrong;
    endtask

    task automatic expect_next(input logic [31:0] exp_pc, input logic exp_taken,
                               input string what);
        #2;
        if (next_pc !== exp_pc) begin
            $display("ERR %0t next_pc expected %h actual %h (%s)", $time, exp_pc, next_pc, what);
            directed_errors++;
        end
        if (predict_taken !== exp_taken) begin
            $display("ERR %0t predict_taken expected %b actual %b (%s)",
                     $time, exp_taken, predict_taken, what);
            directed_errors++;
        end
    endtask

    task automatic fetch_and_expect(input logic valid, input logic [31:0] pc,
                                    input ir_type_pkg::ir_type_e kind,
                                    input logic [31:0] exp_pc, input logic exp_taken,
                                    input string what);
        next_cycle();
        fetch_instr(valid, pc, kind);
        expect_next(exp_pc, exp_taken, what);
    endtask

    task automatic train_entry(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        next_cycle();
        report_resolve(pc, ir_type_pkg::ir_branch, taken, target, 1'b0);
    endtask

    // Small PC window so entries alias and the stack wraps
    task automatic random_inputs();
        logic [31:0] fpc;
        logic [31:0] xpc;
        logic [31:0] target;
        fpc    = 32'h0000_1000 + (($urandom % 32'd64) << 2);
        xpc    = 32'h0000_1000 + (($urandom % 32'd64) << 2);
        target = 32'h0000_2000 + (($urandom % 32'd256) << 2);
        fetch_instr(($urandom % 8) != 0, fpc, ir_type_pkg::ir_type_e'(4'($urandom % 6)));
        if (($urandom % 2) == 0) begin
            report_resolve(xpc, ir_type_pkg::ir_type_e'(4'($urandom % 6)),
                           1'($urandom % 2), target, ($urandom % 6) == 0);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        seed_dummy = $urandom(32'hff02_4f01);
        clear_inputs();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Cold table and empty stack, nothing predicts
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 6; k++) begin
                if (k != int'(ir_type_pkg::ir_call)) begin
                    fetch_and_expect(1'b1, 32'h0000_0200 + i * 4,
                                     ir_type_pkg::ir_type_e'(4'(k)),
                                     32'h0000_0204 + i * 4, 1'b0, "cold lookup");
                end
            end
        end

        // Training, with the same-cycle lookup still seeing the old entry
        next_cycle();
        report_resolve(PC_A, ir_type_pkg::ir_branch, 1'b1, TARGET_A, 1'b0);
        fetch_instr(1'b1, PC_A, ir_type_pkg::ir_branch);
        expect_next(PC_A + 32'd4, 1'b0, "update not yet visible");
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_branch, TARGET_A, 1'b1, "weak_take");
        train_entry(PC_A, 1'b1, TARGET_A);
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_branch, TARGET_A, 1'b1, "strong_take");
        train_entry(PC_A, 1'b0, 32'h0);
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_branch, TARGET_A, 1'b1, "one not taken");
        train_entry(PC_A, 1'b0, 32'h0);
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_branch, PC_A + 32'd4, 1'b0, "two not taken");

        // Aliasing and ir_other on both sides
        train_entry(PC_B, 1'b1, TARGET_B);
        train_entry(PC_B, 1'b1, TARGET_B);
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_jal, TARGET_B, 1'b1, "alias of PC_B");
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_other, PC_A + 32'd4, 1'b0, "ir_other fetch");
        repeat (3) begin
            next_cycle();
            report_resolve(PC_A, ir_type_pkg::ir_other, 1'b0, 32'h0, 1'b0);
        end
        next_cycle();
        report_resolve(PC_A, ir_type_pkg::ir_other, 1'b1, 32'h0000_4444, 1'b0);
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_branch, TARGET_B, 1'b1, "ir_other report");

        // Nested calls return in LIFO order
        for (int i = 0; i < 3; i++) begin
            fetch_and_expect(1'b1, 32'h0000_0500 + i * 32'h100, ir_type_pkg::ir_call,
                             32'h0000_0504 + i * 32'h100, 1'b0, "call push");
        end
        for (int i = 0; i < 3; i++) begin
            fetch_and_expect(1'b1, 32'h0000_0900, ir_type_pkg::ir_ret,
                             32'h0000_0704 - i * 32'h100, 1'b1, "nested return");
        end
        fetch_and_expect(1'b1, PC_A, ir_type_pkg::ir_ret, TARGET_B, 1'b1, "empty ret to table");
        fetch_and_expect(1'b1, 32'h0000_5000, ir_type_pkg::ir_ret, 32'h0000_5004, 1'b0,
                         "empty ret falls through");

        // Nine pushes drop the oldest
        for (int i = 0; i < 9; i++) begin
            fetch_and_expect(1'b1, 32'h0000_4000 + i * 4, ir_type_pkg::ir_call,
                             32'h0000_4004 + i * 4, 1'b0, "overflow push");
        end
        for (int i = 0; i < 8; i++) begin
            fetch_and_expect(1'b1, 32'h0000_5000, ir_type_pkg::ir_ret,
                             32'h0000_4024 - i * 4, 1'b1, "return after overflow");
        end
        fetch_and_expect(1'b1, 32'h0000_5000, ir_type_pkg::ir_ret, 32'h0000_5004, 1'b0,
                         "oldest entry lost");

        // Stalled fetch leaves the stack alone but outputs still follow
        fetch_and_expect(1'b1, 32'h0000_6000, ir_type_pkg::ir_call, 32'h0000_6004, 1'b0, "push");
        fetch_and_expect(1'b0, 32'h0000_7000, ir_type_pkg::ir_call, 32'h0000_7004, 1'b0,
                         "stalled call");
        fetch_and_expect(1'b0, 32'h0000_7100, ir_type_pkg::ir_ret, 32'h0000_6004, 1'b1,
                         "stalled ret");
        fetch_and_expect(1'b0, 32'h0000_7200, ir_type_pkg::ir_ret, 32'h0000_6004, 1'b1,
                         "stack frozen");
        fetch_and_expect(1'b1, 32'h0000_5000, ir_type_pkg::ir_ret, 32'h0000_6004, 1'b1,
                         "ret after stall");
        fetch_and_expect(1'b1, 32'h0000_5000, ir_type_pkg::ir_ret, 32'h0000_5004, 1'b0,
                         "stack empty again");

        // Redirect beats stack and table
        fetch_and_expect(1'b1, 32'h0000_6100, ir_type_pkg::ir_call, 32'h0000_6104, 1'b0, "push");
        next_cycle();
        fetch_instr(1'b1, PC_A, ir_type_pkg::ir_branch);
        report_resolve(32'h0000_8000, ir_type_pkg::ir_branch, 1'b1, 32'h0000_9000, 1'b1);
        expect_next(32'h0000_9000, 1'b0, "taken redirect over table");
        next_cycle();
        fetch_instr(1'b1, 32'h0000_5000, ir_type_pkg::ir_ret);
        report_resolve(32'h0000_8000, ir_type_pkg::ir_branch, 1'b0, 32'h0000_9000, 1'b1);
        expect_next(32'h0000_8004, 1'b0, "not-taken redirect over stack");
        next_cycle();
        fetch_instr(1'b1, 32'h0000_6200, ir_type_pkg::ir_call);
        report_resolve(32'h0000_8000, ir_type_pkg::ir_jalr, 1'b1, 32'h0000_9100, 1'b1);
        expect_next(32'h0000_9100, 1'b0, "redirect during call");

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            next_cycle();
            random_inputs();
        end
        next_cycle();
        repeat (2) @(posedge clk);

        if (checks_done < RANDOM_CYCLES) begin
            $display("Checker compared only %0d cycles, fewer than the random phase",
                     checks_done);
            directed_errors++;
        end
        $display("Checked %0d cycles: %0d checker errors, %0d directed errors",
                 checks_done, checker_errors, directed_errors);
        if (checker_errors == 0 && directed_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
